// ==== spu_issue_pkg.sv ====
package spu_issue_pkg;

  // instruction word layout
  localparam int instr_width = 32;
  localparam int opcode_width = 7;
  localparam int op_lsb = instr_width - opcode_width; // opcode sits in bits 31..25

  // register field positions, field width comes from reg_addr_width
  localparam int rt_lsb = 0;
  localparam int ra_lsb = 7;
  localparam int rb_lsb = 14;

  // opcode bit 5 set marks store-like ops which write no rt
  localparam int store_bit = 5;

  // fill codes for empty slots
  localparam logic [opcode_width-1:0] op_nop = 7'h00;  // even pipe
  localparam logic [opcode_width-1:0] op_lnop = 7'h40; // odd pipe

  // opcode msb picks the pipe
  typedef enum logic {
    pipe_even = 1'b0,
    pipe_odd = 1'b1
  } pipe_e;

endpackage

// ==== instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode #(
  parameter int reg_addr_width = 7
) (
  input  logic [spu_issue_pkg::instr_width-1:0]  instr,
  input  logic                                   in_valid,
  output logic [spu_issue_pkg::opcode_width-1:0] op,
  output logic [reg_addr_width-1:0]              rt,
  output logic [reg_addr_width-1:0]              ra,
  output logic [reg_addr_width-1:0]              rb,
  output spu_issue_pkg::pipe_e                   pipe,
  output logic                                   writes
);

  import spu_issue_pkg::*;

  logic is_fill;
  logic is_store;

  // field extraction
  assign op = instr[op_lsb +: opcode_width];
  assign rt = instr[rt_lsb +: reg_addr_width];
  assign ra = instr[ra_lsb +: reg_addr_width];
  assign rb = instr[rb_lsb +: reg_addr_width];

  // pipe class straight from the opcode msb
  assign pipe = pipe_e'(op[opcode_width-1]);

  // nop and lnop never write, neither do store-like ops
  assign is_fill = (op == op_nop) || (op == op_lnop);
  assign is_store = op[store_bit];

  assign writes = in_valid && !is_fill && !is_store;

endmodule

// ==== issue_control.sv ====
`timescale 1ns/10ps

module issue_control #(
  parameter int reg_addr_width = 7
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  spu_issue_pkg::pipe_e      pipe1,
  input  spu_issue_pkg::pipe_e      pipe2,
  input  logic                      writes1,
  input  logic [reg_addr_width-1:0] rt1,
  input  logic [reg_addr_width-1:0] ra2,
  input  logic [reg_addr_width-1:0] rb2,
  output logic                      issue1,
  output logic                      issue2,
  output logic                      stall
);

  logic pending; // second half of a split pair still owed
  logic pipe_clash;
  logic reg_dep;
  logic conflict;

  assign pipe_clash = (pipe1 == pipe2);
  assign reg_dep = writes1 && ((rt1 == ra2) || (rt1 == rb2)); // instr2 reads instr1's rt
  assign conflict = in_valid && (pipe_clash || reg_dep);

  always_comb begin
    issue1 = 1'b0;
    issue2 = 1'b0;
    stall = 1'b0;
    if (pending) begin
      // fetch is holding the pair, send the second one alone
      issue2 = 1'b1;
    end else if (conflict) begin
      issue1 = 1'b1;
      stall = 1'b1;
    end else if (in_valid) begin
      issue1 = 1'b1;
      issue2 = 1'b1;
    end
  end

  // a stall cycle is always followed by the hold cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= stall;
    end
  end

endmodule

// ==== pipe_route.sv ====
`timescale 1ns/10ps

module pipe_route #(
  parameter int reg_addr_width = 7
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   issue1,
  input  logic                                   issue2,
  input  logic [spu_issue_pkg::opcode_width-1:0] op1,
  input  logic [reg_addr_width-1:0]              rt1,
  input  logic [reg_addr_width-1:0]              ra1,
  input  logic [reg_addr_width-1:0]              rb1,
  input  spu_issue_pkg::pipe_e                   pipe1,
  input  logic                                   writes1,
  input  logic [spu_issue_pkg::opcode_width-1:0] op2,
  input  logic [reg_addr_width-1:0]              rt2,
  input  logic [reg_addr_width-1:0]              ra2,
  input  logic [reg_addr_width-1:0]              rb2,
  input  spu_issue_pkg::pipe_e                   pipe2,
  input  logic                                   writes2,
  output logic [spu_issue_pkg::opcode_width-1:0] even_op,
  output logic [reg_addr_width-1:0]              even_rt,
  output logic [reg_addr_width-1:0]              even_ra,
  output logic [reg_addr_width-1:0]              even_rb,
  output logic                                   even_reg_wr,
  output logic [spu_issue_pkg::opcode_width-1:0] odd_op,
  output logic [reg_addr_width-1:0]              odd_rt,
  output logic [reg_addr_width-1:0]              odd_ra,
  output logic [reg_addr_width-1:0]              odd_rb,
  output logic                                   odd_reg_wr
);

  import spu_issue_pkg::*;

  logic sel1_even;
  logic sel1_odd;
  logic sel2_even;
  logic sel2_odd;

  // issue control never lets both instructions claim the same pipe
  assign sel1_even = issue1 && (pipe1 == pipe_even);
  assign sel1_odd = issue1 && (pipe1 == pipe_odd);
  assign sel2_even = issue2 && (pipe2 == pipe_even);
  assign sel2_odd = issue2 && (pipe2 == pipe_odd);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      even_op <= op_nop;
      even_rt <= '0;
      even_ra <= '0;
      even_rb <= '0;
      even_reg_wr <= 1'b0;
      odd_op <= op_lnop;
      odd_rt <= '0;
      odd_ra <= '0;
      odd_rb <= '0;
      odd_reg_wr <= 1'b0;
    end else begin
      // even slot
      if (sel1_even) begin
        even_op <= op1;
        even_rt <= rt1;
        even_ra <= ra1;
        even_rb <= rb1;
        even_reg_wr <= writes1;
      end else if (sel2_even) begin
        even_op <= op2;
        even_rt <= rt2;
        even_ra <= ra2;
        even_rb <= rb2;
        even_reg_wr <= writes2;
      end else begin
        even_op <= op_nop; // nothing for the even pipe this cycle
        even_rt <= '0;
        even_ra <= '0;
        even_rb <= '0;
        even_reg_wr <= 1'b0;
      end

      // odd slot
      if (sel1_odd) begin
        odd_op <= op1;
        odd_rt <= rt1;
        odd_ra <= ra1;
        odd_rb <= rb1;
        odd_reg_wr <= writes1;
      end else if (sel2_odd) begin
        odd_op <= op2;
        odd_rt <= rt2;
        odd_ra <= ra2;
        odd_rb <= rb2;
        odd_reg_wr <= writes2;
      end else begin
        odd_op <= op_lnop;
        odd_rt <= '0;
        odd_ra <= '0;
        odd_rb <= '0;
        odd_reg_wr <= 1'b0;
      end
    end
  end

endmodule

// ==== dual_issue_stage.sv ====
`timescale 1ns/10ps

module dual_issue_stage #(
  parameter int reg_addr_width = 7
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [spu_issue_pkg::instr_width-1:0]  instr1,
  input  logic [spu_issue_pkg::instr_width-1:0]  instr2,
  input  logic                                   in_valid,
  output logic                                   stall,
  output logic [spu_issue_pkg::opcode_width-1:0] even_op,
  output logic [reg_addr_width-1:0]              even_rt,
  output logic [reg_addr_width-1:0]              even_ra,
  output logic [reg_addr_width-1:0]              even_rb,
  output logic                                   even_reg_wr,
  output logic [spu_issue_pkg::opcode_width-1:0] odd_op,
  output logic [reg_addr_width-1:0]              odd_rt,
  output logic [reg_addr_width-1:0]              odd_ra,
  output logic [reg_addr_width-1:0]              odd_rb,
  output logic                                   odd_reg_wr
);

  import spu_issue_pkg::*;

  logic [opcode_width-1:0]   op1, op2;
  logic [reg_addr_width-1:0] rt1, ra1, rb1;
  logic [reg_addr_width-1:0] rt2, ra2, rb2;
  pipe_e                     pipe1, pipe2;
  logic                      writes1, writes2;
  logic                      issue1, issue2;

  instr_decode #(.reg_addr_width(reg_addr_width)) dec1 (
    .instr    (instr1),
    .in_valid (in_valid),
    .op       (op1),
    .rt       (rt1),
    .ra       (ra1),
    .rb       (rb1),
    .pipe     (pipe1),
    .writes   (writes1)
  );

  instr_decode #(.reg_addr_width(reg_addr_width)) dec2 (
    .instr    (instr2),
    .in_valid (in_valid),
    .op       (op2),
    .rt       (rt2),
    .ra       (ra2),
    .rb       (rb2),
    .pipe     (pipe2),
    .writes   (writes2)
  );

  // stall back to fetch is combinational
  issue_control #(.reg_addr_width(reg_addr_width)) u_issue_control (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .pipe1    (pipe1),
    .pipe2    (pipe2),
    .writes1  (writes1),
    .rt1      (rt1),
    .ra2      (ra2),
    .rb2      (rb2),
    .issue1   (issue1),
    .issue2   (issue2),
    .stall    (stall)
  );

  pipe_route #(.reg_addr_width(reg_addr_width)) u_pipe_route (
    .clk         (clk),
    .rst         (rst),
    .issue1      (issue1),
    .issue2      (issue2),
    .op1         (op1),
    .rt1         (rt1),
    .ra1         (ra1),
    .rb1         (rb1),
    .pipe1       (pipe1),
    .writes1     (writes1),
    .op2         (op2),
    .rt2         (rt2),
    .ra2         (ra2),
    .rb2         (rb2),
    .pipe2       (pipe2),
    .writes2     (writes2),
    .even_op     (even_op),
    .even_rt     (even_rt),
    .even_ra     (even_ra),
    .even_rb     (even_rb),
    .even_reg_wr (even_reg_wr),
    .odd_op      (odd_op),
    .odd_rt      (odd_rt),
    .odd_ra      (odd_ra),
    .odd_rb      (odd_rb),
    .odd_reg_wr  (odd_reg_wr)
  );

endmodule

// ==== issue_assertions.sv ====
`timescale 1ns/10ps

module issue_assertions (
  input logic                                   clk,
  input logic                                   rst,
  input logic                                   stall,
  input logic [spu_issue_pkg::opcode_width-1:0] even_op,
  input logic [spu_issue_pkg::opcode_width-1:0] odd_op
);

  import spu_issue_pkg::*;

  logic even_real;
  logic odd_real;

  assign even_real = (even_op != op_nop);
  assign odd_real = (odd_op != op_lnop);

  // a split pair holds fetch for one cycle only
  stall_once: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
    else $error("stall high on two cycles in a row");

  same_class: assert property (@(posedge clk) disable iff (rst)
      !(even_real && odd_real && (even_op[opcode_width-1] == odd_op[opcode_width-1])))
    else $error("even and odd slots carry instructions of the same pipe class");

  slot_class: assert property (@(posedge clk) disable iff (rst)
      !even_op[opcode_width-1] && odd_op[opcode_width-1])
    else $error("a slot carries an instruction of the other pipe");

endmodule

bind dual_issue_stage issue_assertions u_assertions (
  .clk     (clk),
  .rst     (rst),
  .stall   (stall),
  .even_op (even_op),
  .odd_op  (odd_op)
);

// ==== issue_checker.sv ====
`timescale 1ns/10ps

module issue_checker #(
  parameter int reg_addr_width = 7
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [spu_issue_pkg::instr_width-1:0]  instr1,
  input  logic [spu_issue_pkg::instr_width-1:0]  instr2,
  input  logic                                   in_valid,
  input  logic                                   stall,
  input  logic [spu_issue_pkg::opcode_width-1:0] even_op,
  input  logic [reg_addr_width-1:0]              even_rt, even_ra, even_rb,
  input  logic                                   even_reg_wr,
  input  logic [spu_issue_pkg::opcode_width-1:0] odd_op,
  input  logic [reg_addr_width-1:0]              odd_rt, odd_ra, odd_rb,
  input  logic                                   odd_reg_wr,
  input  logic                                   table_check, // first sample of a table entry
  input  logic                                   table_split,
  output int                                     check_count,
  output int                                     error_count
);

  import spu_issue_pkg::*;

  localparam int slot_w = opcode_width + 3 * reg_addr_width + 1;

  logic              pending;            // second half of a split pair still owed
  logic [slot_w-1:0] exp_even, exp_odd;  // {op, rt, ra, rb, reg_wr}
  logic              exp_stall;
  logic              wr1, wr2, dep, conflict;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_slot(input string pipe, input logic [slot_w-1:0] got,
                            input logic [slot_w-1:0] exp);
    check_val({pipe, "_op"}, 32'(got[slot_w-1 -: opcode_width]), 32'(exp[slot_w-1 -: opcode_width]));
    check_val({pipe, "_rt"}, 32'(got[1+2*reg_addr_width +: reg_addr_width]),
              32'(exp[1+2*reg_addr_width +: reg_addr_width]));
    check_val({pipe, "_ra"}, 32'(got[1+reg_addr_width +: reg_addr_width]),
              32'(exp[1+reg_addr_width +: reg_addr_width]));
    check_val({pipe, "_rb"}, 32'(got[1 +: reg_addr_width]), 32'(exp[1 +: reg_addr_width]));
    check_val({pipe, "_reg_wr"}, 32'(got[0]), 32'(exp[0]));
  endtask

  // only a real op that is not store-like and sits in a valid pair writes rt
  function automatic logic writes_rt(input logic [31:0] w, input logic valid);
    return valid && (w[31:25] != op_nop) && (w[31:25] != op_lnop) && !w[30];
  endfunction

  function automatic logic [slot_w-1:0] slot_of(input logic [31:0] w, input logic wr);
    return {w[31:25], w[0 +: reg_addr_width], w[7 +: reg_addr_width],
            w[14 +: reg_addr_width], wr};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      pending = 1'b0;
      check_count = 0;
      error_count = 0;
      exp_even = {op_nop, {(slot_w-opcode_width){1'b0}}};
      exp_odd = {op_lnop, {(slot_w-opcode_width){1'b0}}};
    end else begin
      // outputs still show what the previous edge registered
      check_slot("even", {even_op, even_rt, even_ra, even_rb, even_reg_wr}, exp_even);
      check_slot("odd", {odd_op, odd_rt, odd_ra, odd_rb, odd_reg_wr}, exp_odd);

      wr1 = writes_rt(instr1, in_valid);
      wr2 = writes_rt(instr2, in_valid);
      dep = wr1 && ((instr1[0 +: reg_addr_width] == instr2[7 +: reg_addr_width]) ||
                    (instr1[0 +: reg_addr_width] == instr2[14 +: reg_addr_width]));
      conflict = in_valid && ((instr1[31] == instr2[31]) || dep); // opcode msb is the pipe
      exp_stall = !pending && conflict;
      check_val("stall", 32'(stall), 32'(exp_stall));
      if (table_check) begin
        check_val("stall", 32'(stall), 32'(table_split));
      end

      exp_even = {op_nop, {(slot_w-opcode_width){1'b0}}};
      exp_odd = {op_lnop, {(slot_w-opcode_width){1'b0}}};
      if (pending) begin
        if (instr2[31]) exp_odd = slot_of(instr2, wr2);
        else exp_even = slot_of(instr2, wr2);
      end else if (in_valid) begin
        if (instr1[31]) exp_odd = slot_of(instr1, wr1);
        else exp_even = slot_of(instr1, wr1);
        if (!conflict && instr2[31]) exp_odd = slot_of(instr2, wr2);
        if (!conflict && !instr2[31]) exp_even = slot_of(instr2, wr2);
      end
      pending = exp_stall;
    end
  end

endmodule

// ==== tb_dual_issue.sv ====
`timescale 1ns/10ps

module tb_dual_issue;

  import spu_issue_pkg::*;

  localparam int reg_addr_width = 7;
  localparam int num_entries = 12;
  localparam int num_random = 200;
  // a pair needs at most two cycles, four gives plenty of slack
  localparam int watchdog_ns = (4 * (num_entries + num_random) + 20) * 100;
  localparam logic [31:0] reg_mask = 32'hffe1_c387; // register numbers 0..7 so deps show up

  logic                      clk;
  logic                      rst;
  logic [instr_width-1:0]    instr1, instr2;
  logic                      in_valid;
  logic                      stall;
  logic [opcode_width-1:0]   even_op, odd_op;
  logic [reg_addr_width-1:0] even_rt, even_ra, even_rb, odd_rt, odd_ra, odd_rb;
  logic                      even_reg_wr, odd_reg_wr;
  logic                      stall_q; // stall as fetch saw it at the last edge
  logic                      table_check, table_split;
  int                        check_count, error_count;
  int                        n_loaded;
  logic [31:0]               tbl_instr1 [num_entries];
  logic [31:0]               tbl_instr2 [num_entries];
  logic                      tbl_valid [num_entries];
  logic                      tbl_split [num_entries]; // pair is expected to stall once
  logic [31:0]               rnd, rnd_a, rnd_b;

  dual_issue_stage #(.reg_addr_width(reg_addr_width)) dut (.*);

  issue_checker #(.reg_addr_width(reg_addr_width)) chk (.*);

  function automatic logic [31:0] encode_instr(input int op, input int rt, input int ra, input int rb);
    return {7'(op), 4'b0000, 7'(rb), 7'(ra), 7'(rt)};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_entry(input logic [31:0] a, input logic [31:0] b, input logic v, input logic s);
    tbl_instr1[n_loaded] = a;
    tbl_instr2[n_loaded] = b;
    tbl_valid[n_loaded] = v;
    tbl_split[n_loaded] = s;
    n_loaded++;
  endtask

  // starts on a falling edge and returns on the falling edge after the pair is taken
  task automatic apply_pair(input logic [31:0] a, input logic [31:0] b, input logic v,
                            input logic from_table, input logic split);
    instr1 = a;
    instr2 = b;
    in_valid = v;
    table_check = from_table;
    table_split = split;
    @(negedge clk);
    table_check = 1'b0;
    while (stall_q) begin
      @(negedge clk); // hold the same pair for the second issue
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) stall_q <= stall;

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the test sequence finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    instr1 = '0;
    instr2 = '0;
    in_valid = 1'b0;
    table_check = 1'b0;
    table_split = 1'b0;
    n_loaded = 0;
    rnd = 32'he401_5622;
    // op, rt, ra, rb of each instruction, then in_valid and expected split
    add_entry(encode_instr('h01, 3, 1, 2), encode_instr('h41, 4, 5, 6), 1'b1, 1'b0);
    add_entry(encode_instr('h45, 7, 1, 2), encode_instr('h0a, 8, 3, 4), 1'b1, 1'b0);
    add_entry(encode_instr('h02, 9, 1, 2), encode_instr('h03, 10, 3, 4), 1'b1, 1'b1);
    add_entry(encode_instr('h42, 11, 1, 2), encode_instr('h43, 12, 3, 4), 1'b1, 1'b1);
    add_entry(encode_instr('h04, 13, 1, 2), encode_instr('h44, 14, 13, 5), 1'b1, 1'b1);
    add_entry(encode_instr('h46, 15, 1, 2), encode_instr('h06, 16, 3, 15), 1'b1, 1'b1);
    add_entry(encode_instr('h21, 17, 1, 2), encode_instr('h47, 18, 17, 17), 1'b1, 1'b0);
    add_entry(encode_instr('h01, 3, 1, 2), encode_instr('h01, 4, 5, 6), 1'b0, 1'b0);
    add_entry(encode_instr('h00, 0, 0, 0), encode_instr('h40, 0, 0, 0), 1'b1, 1'b0);
    add_entry(encode_instr('h40, 5, 0, 0), encode_instr('h07, 6, 5, 5), 1'b1, 1'b0);
    add_entry(encode_instr('h61, 19, 1, 2), encode_instr('h08, 20, 19, 1), 1'b1, 1'b0);
    add_entry(encode_instr('h09, 0, 1, 2), encode_instr('h48, 21, 0, 3), 1'b1, 1'b1);

    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      apply_pair(tbl_instr1[i], tbl_instr2[i], tbl_valid[i], 1'b1, tbl_split[i]);
    end
    for (int i = 0; i < num_random; i++) begin
      rnd = xorshift(rnd);
      rnd_a = rnd & reg_mask;
      rnd = xorshift(rnd);
      rnd_b = rnd & reg_mask;
      rnd = xorshift(rnd);
      apply_pair(rnd_a, rnd_b, rnd[2:0] != 3'b000, 1'b0, 1'b0);
    end
    // idle pairs let the last results reach the checker
    apply_pair('0, '0, 1'b0, 1'b0, 1'b0);
    apply_pair('0, '0, 1'b0, 1'b0, 1'b0);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
spu_issue_pkg.sv
instr_decode.sv
issue_control.sv
pipe_route.sv
dual_issue_stage.sv
issue_assertions.sv
issue_checker.sv
tb_dual_issue.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dual issue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_dual_issue \
  -f compile.f -o tb_dual_issue > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_dual_issue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
exit 1
